// File: nxt_defs.svh
`ifndef NXT_DEFS_SVH
`define NXT_DEFS_SVH

// width of the datapath and of every address
`define NXT_XLEN 32

// program counter value loaded while rst_n is low
`define NXT_PC_RESET 32'h0000_0000

// byte distance between two sequential instructions
`define NXT_STEP 4

`endif

// File: nxt_pkg.sv
package nxt_pkg;

    // control flow operation as delivered by the decoder
    typedef enum logic [3:0] {
        CF_NONE   = 4'd0,
        CF_J      = 4'd1,
        CF_JAL    = 4'd2,
        CF_JR     = 4'd3,
        CF_JALR   = 4'd4,
        CF_BEQ    = 4'd5,
        CF_BNE    = 4'd6,
        CF_BGEZ   = 4'd7,
        CF_BGEZAL = 4'd8,
        CF_BGTZ   = 4'd9,
        CF_BLEZ   = 4'd10,
        CF_BLTZ   = 4'd11,
        CF_BLTZAL = 4'd12
    } cf_op_e;

    // every instruction spends one cycle in each phase
    typedef enum logic {
        PH_FETCH = 1'b0,
        PH_EXEC  = 1'b1
    } phase_e;

endpackage

// File: branch_cond.sv
`timescale 1ns/1ps
`include "nxt_defs.svh"

module branch_cond (
    input  nxt_pkg::cf_op_e      op,
    input  logic [`NXT_XLEN-1:0] r_s,
    input  logic [`NXT_XLEN-1:0] r_t,
    output logic                 taken,
    output logic                 link_req
);
    import nxt_pkg::*;

    logic rs_neg;
    logic rs_zero;
    logic rs_eq_rt;

    // r_s is treated as a two's complement number
    assign rs_neg   = r_s[`NXT_XLEN-1];
    assign rs_zero  = (r_s == '0);
    assign rs_eq_rt = (r_s == r_t);

    // ########################################
    // taken decision
    // ########################################

    always_comb begin
        case (op)
            CF_J, CF_JAL, CF_JR, CF_JALR: taken = 1'b1;
            CF_BEQ:                       taken = rs_eq_rt;
            CF_BNE:                       taken = !rs_eq_rt;
            CF_BGEZ, CF_BGEZAL:           taken = !rs_neg;
            CF_BGTZ:                      taken = !rs_neg && !rs_zero;
            CF_BLEZ:                      taken = rs_neg || rs_zero;
            CF_BLTZ, CF_BLTZAL:           taken = rs_neg;
            default:                      taken = 1'b0;
        endcase
    end

    // ########################################
    // link request
    // ########################################

    // the linking branches only write the return address when they are taken
    always_comb begin
        case (op)
            CF_JAL, CF_JALR:       link_req = 1'b1;
            CF_BGEZAL, CF_BLTZAL:  link_req = taken;
            default:               link_req = 1'b0;
        endcase
    end

endmodule

// File: branch_target.sv
`timescale 1ns/1ps
`include "nxt_defs.svh"

module branch_target (
    input  nxt_pkg::cf_op_e      op,
    input  logic [`NXT_XLEN-1:0] pc,
    input  logic [`NXT_XLEN-1:0] r_s,
    input  logic [15:0]          imm16,
    input  logic [25:0]          imm26,
    output logic [`NXT_XLEN-1:0] target,
    output logic [`NXT_XLEN-1:0] link_addr
);
    import nxt_pkg::*;

    logic [`NXT_XLEN-1:0] pc_plus4;
    logic [`NXT_XLEN-1:0] region_addr;
    logic [`NXT_XLEN-1:0] branch_offset;
    logic [`NXT_XLEN-1:0] rel_addr;

    assign pc_plus4 = pc + `NXT_STEP;

    // ########################################
    // address forms
    // ########################################

    // J and JAL stay inside the 256 MB region of the delay slot address
    assign region_addr = {pc_plus4[`NXT_XLEN-1 -: 4], imm26, 2'b00};

    // word offset, sign extended and scaled to bytes
    assign branch_offset = {{(`NXT_XLEN-18){imm16[15]}}, imm16, 2'b00};
    assign rel_addr      = pc_plus4 + branch_offset;

    always_comb begin
        case (op)
            CF_JR, CF_JALR: target = r_s;
            CF_J, CF_JAL:   target = region_addr;
            default:        target = rel_addr;
        endcase
    end

    // return address skips the instruction after the jump
    assign link_addr = pc + 2 * `NXT_STEP;

endmodule

// File: pc_sequencer.sv
`timescale 1ns/1ps
`include "nxt_defs.svh"

module pc_sequencer (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 stall,
    input  logic                 taken,
    input  logic                 link_req,
    input  logic [`NXT_XLEN-1:0] target,
    output logic [`NXT_XLEN-1:0] pc,
    output nxt_pkg::phase_e      phase,
    output logic                 link
);
    import nxt_pkg::*;

    logic [`NXT_XLEN-1:0] pc_next;
    phase_e               phase_next;

    // ########################################
    // next state
    // ########################################

    // the update at the end of execute goes ahead even when stall rises in
    // that cycle because the instruction has already completed
    always_comb begin
        if (phase == PH_EXEC) begin
            pc_next = taken ? target : pc + `NXT_STEP;
        end else begin
            pc_next = pc;
        end
    end

    always_comb begin
        if (stall) begin
            phase_next = PH_FETCH;
        end else if (phase == PH_FETCH) begin
            phase_next = PH_EXEC;
        end else begin
            phase_next = PH_FETCH;
        end
    end

    // ########################################
    // registers
    // ########################################

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc    <= `NXT_PC_RESET;
            phase <= PH_FETCH;
        end else begin
            pc    <= pc_next;
            phase <= phase_next;
        end
    end

    // op is only meaningful during execute
    assign link = link_req && (phase == PH_EXEC);

    // a register jump to an unaligned address would break word alignment
    a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        (pc[1:0] == 2'b00) |=> (pc[1:0] == 2'b00))
        else $error("pc lost word alignment: %h", pc);

    a_stall_fetch: assert property (@(posedge clk) disable iff (!rst_n)
        stall |=> (phase == PH_FETCH))
        else $error("phase not back in fetch after a stall");

endmodule

// File: next_pc_unit.sv
`timescale 1ns/1ps
`include "nxt_defs.svh"

module next_pc_unit (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 stall,
    input  nxt_pkg::cf_op_e      op,
    input  logic [`NXT_XLEN-1:0] r_s,
    input  logic [`NXT_XLEN-1:0] r_t,
    input  logic [15:0]          imm16,
    input  logic [25:0]          imm26,
    output logic [`NXT_XLEN-1:0] pc,
    output nxt_pkg::phase_e      phase,
    output logic                 link,
    output logic [`NXT_XLEN-1:0] link_addr
);

    logic                 taken;
    logic                 link_req;
    logic [`NXT_XLEN-1:0] target;

    // decision and target are formed in parallel from the same operands
    branch_cond u_cond (
        .op       (op),
        .r_s      (r_s),
        .r_t      (r_t),
        .taken    (taken),
        .link_req (link_req)
    );

    branch_target u_target (
        .op        (op),
        .pc        (pc),
        .r_s       (r_s),
        .imm16     (imm16),
        .imm26     (imm26),
        .target    (target),
        .link_addr (link_addr)
    );

    pc_sequencer u_seq (
        .clk      (clk),
        .rst_n    (rst_n),
        .stall    (stall),
        .taken    (taken),
        .link_req (link_req),
        .target   (target),
        .pc       (pc),
        .phase    (phase),
        .link     (link)
    );

endmodule

// File: tb_next_pc_unit.sv
`timescale 1ns/1ps
`include "nxt_defs.svh"

module tb_next_pc_unit;
    import nxt_pkg::*;

    localparam int NUM_INSTR  = 400;
    // 400 instructions at two cycles each, plus reset and stall margin
    localparam int MAX_CYCLES = 2000;

    logic                 clk;
    logic                 rst_n;
    logic                 stall;
    cf_op_e               op;
    logic [`NXT_XLEN-1:0] r_s;
    logic [`NXT_XLEN-1:0] r_t;
    logic [15:0]          imm16;
    logic [25:0]          imm26;
    logic [`NXT_XLEN-1:0] pc;
    phase_e               phase;
    logic                 link;
    logic [`NXT_XLEN-1:0] link_addr;

    logic [`NXT_XLEN-1:0] model_pc;
    phase_e               model_phase;
    logic                 exp_link;
    logic [`NXT_XLEN-1:0] exp_link_addr;
    int                   retired;
    int                   cycles = 0;
    integer               seed;

    next_pc_unit u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .stall     (stall),
        .op        (op),
        .r_s       (r_s),
        .r_t       (r_t),
        .imm16     (imm16),
        .imm26     (imm26),
        .pc        (pc),
        .phase     (phase),
        .link      (link),
        .link_addr (link_addr)
    );

    // ########################################
    // reference model
    // ########################################

    function automatic logic is_taken(cf_op_e o, logic [`NXT_XLEN-1:0] rs,
                                      logic [`NXT_XLEN-1:0] rt);
        logic signed [`NXT_XLEN-1:0] s;
        s = rs;
        case (o)
            CF_J, CF_JAL, CF_JR, CF_JALR: return 1'b1;
            CF_BEQ:                       return rs == rt;
            CF_BNE:                       return rs != rt;
            CF_BGEZ, CF_BGEZAL:           return s >= 0;
            CF_BGTZ:                      return s > 0;
            CF_BLEZ:                      return s <= 0;
            CF_BLTZ, CF_BLTZAL:           return s < 0;
            default:                      return 1'b0;
        endcase
    endfunction

    function automatic logic wants_link(cf_op_e o, logic [`NXT_XLEN-1:0] rs,
                                        logic [`NXT_XLEN-1:0] rt);
        if (o == CF_JAL || o == CF_JALR)
            return 1'b1;
        if (o == CF_BGEZAL || o == CF_BLTZAL)
            return is_taken(o, rs, rt);
        return 1'b0;
    endfunction

    function automatic logic [`NXT_XLEN-1:0] predict_next_pc(
        cf_op_e o, logic [`NXT_XLEN-1:0] cur, logic [`NXT_XLEN-1:0] rs,
        logic [`NXT_XLEN-1:0] rt, logic [15:0] i16, logic [25:0] i26);
        logic [`NXT_XLEN-1:0]        seq;
        logic signed [`NXT_XLEN-1:0] off;
        seq = cur + 32'd4;
        off = $signed(i16) * 4;
        if (!is_taken(o, rs, rt))
            return seq;
        case (o)
            CF_J, CF_JAL:   return (seq & 32'hf000_0000) | (i26 * 4);
            CF_JR, CF_JALR: return rs;
            default:        return seq + off;
        endcase
    endfunction

    // the model only moves pc at an edge that closes the execute phase
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            model_pc    <= `NXT_PC_RESET;
            model_phase <= PH_FETCH;
            retired     <= 0;
        end else begin
            if (model_phase == PH_EXEC) begin
                model_pc <= predict_next_pc(op, model_pc, r_s, r_t, imm16, imm26);
                retired  <= retired + 1;
            end
            if (stall || model_phase == PH_EXEC)
                model_phase <= PH_FETCH;
            else
                model_phase <= PH_EXEC;
        end
    end

    assign exp_link      = (model_phase == PH_EXEC) && wants_link(op, r_s, r_t);
    assign exp_link_addr = model_pc + 32'd8;

    // ########################################
    // checking
    // ########################################

    task automatic fail_run();
        $display("Verification failed");
        $fatal(1, "stopping at the first failure");
    endtask

    task automatic report_mismatch(string name, logic [31:0] expected, logic [31:0] got);
        $display("ERR time=%0t signal=%s expected=%h got=%h", $time, name, expected, got);
        fail_run();
    endtask

    a_pc_match: assert property (@(posedge clk) disable iff (!rst_n) pc == model_pc)
        else report_mismatch("pc", $sampled(model_pc), $sampled(pc));

    a_phase_match: assert property (@(posedge clk) disable iff (!rst_n) phase == model_phase)
        else report_mismatch("phase", {31'b0, $sampled(model_phase)}, {31'b0, $sampled(phase)});

    a_link_match: assert property (@(posedge clk) disable iff (!rst_n) link == exp_link)
        else report_mismatch("link", {31'b0, $sampled(exp_link)}, {31'b0, $sampled(link)});

    a_link_addr_match: assert property (@(posedge clk) disable iff (!rst_n)
        (model_phase != PH_EXEC) || (link_addr == exp_link_addr))
        else report_mismatch("link_addr", $sampled(exp_link_addr), $sampled(link_addr));

    // ########################################
    // stimulus
    // ########################################

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // a new instruction starts whenever the next cycle is a fetch cycle
    always @(posedge clk) begin : drive_inputs
        logic [`NXT_XLEN-1:0] rs_v;
        logic [`NXT_XLEN-1:0] rt_v;
        logic [31:0]          mode_r;
        int unsigned          op_idx;
        if (rst_n) begin
            stall <= (($random(seed) & 7) == 0);
            if (stall || phase == PH_EXEC) begin
                op_idx = $unsigned($random(seed)) % 13;
                rs_v   = $random(seed);
                rt_v   = $random(seed);
                mode_r = $random(seed);
                case (mode_r[1:0])
                    2'd1:    rt_v = rs_v;
                    2'd2:    rs_v = '0;
                    2'd3:    rs_v[`NXT_XLEN-1] = 1'b1;
                    default: rs_v = rs_v;
                endcase
                // register jumps keep the program counter word aligned
                if (op_idx == 3 || op_idx == 4)
                    rs_v[1:0] = 2'b00;
                op    <= cf_op_e'(op_idx[3:0]);
                r_s   <= rs_v;
                r_t   <= rt_v;
                imm16 <= 16'($random(seed));
                imm26 <= 26'($random(seed));
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("run timed out after %0d cycles with %0d of %0d instructions retired",
                     cycles, retired, NUM_INSTR);
            fail_run();
        end
    end

    initial begin
        seed  = 32'h2da0;
        rst_n = 1'b0;
        stall = 1'b0;
        op    = CF_NONE;
        r_s   = '0;
        r_t   = '0;
        imm16 = '0;
        imm26 = '0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        assert (pc == `NXT_PC_RESET) else report_mismatch("pc", `NXT_PC_RESET, pc);
        assert (phase == PH_FETCH) else report_mismatch("phase", {31'b0, PH_FETCH}, {31'b0, phase});
        assert (!link) else report_mismatch("link", 32'd0, {31'b0, link});
        wait (retired == NUM_INSTR);
        // one more edge lets the last pc update be compared
        @(posedge clk);
        @(negedge clk);
        $display("Verification passed");
        $finish;
    end

endmodule

// File: verilog.f
+incdir+.
nxt_pkg.sv
branch_cond.sv
branch_target.sv
pc_sequencer.sv
next_pc_unit.sv
tb_next_pc_unit.sv

// File: run.sh
#!/bin/sh
# build and run the next_pc_unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

if ! verilator --binary --timing --assert \
        -f verilog.f \
        --top-module tb_next_pc_unit \
        -o sim_tb > "$BUILD_LOG" 2>&1; then
    echo "build failed, see $BUILD_LOG"
    exit 1
fi

if ! ./obj_dir/sim_tb > "$SIM_LOG" 2>&1; then
    echo "simulation returned a failing status, see $SIM_LOG"
    exit 1
fi

if grep -q "^Verification passed$" "$SIM_LOG"; then
    echo "PASS"
    exit 0
else
    echo "FAIL, see $SIM_LOG"
    exit 1
fi
